// File: Bender.yml
package:
  name: ctr_stream

sources:
  - ctr_pkg.sv
  - sync_fifo.sv
  - axis_block_packer.sv
  - ctr_keystream.sv
  - block_combiner.sv
  - axis_block_unpacker.sv
  - ctr_stream_top.sv
  - target: test
    files:
      - ctr_stream_assertions.sv
      - tb_ctr_stream.sv

// File: axis_block_packer.sv
`timescale 1ns/100ps
`default_nettype none

module axis_block_packer
	import ctr_pkg::*;
(
	input  logic    aclk,
	input  logic    rst_n,
	input  logic    s_axis_tvalid,
	input  logic    s_axis_tlast,
	input  word_t   s_axis_tdata,
	output logic    s_axis_tready,
	input  logic    space_ok,
	output logic    blk_valid,
	output block_t  blk_data,
	output ks_req_t ks_req
);

	typedef enum logic [1:0] {S_CMD, S_KEY, S_DATA, S_SKIP} state_t;

	state_t state;
	logic [1:0] word_idx;
	block_t key_q;
	logic [23:0] nonce_q;
	word_t ctr_q;
	block_t shift_q;
	logic last_q;
	logic accept;
	cmd_t cmd;

	// input stalls only on lack of room downstream
	assign s_axis_tready = space_ok;
	assign accept = s_axis_tvalid && space_ok;
	assign cmd = cmd_t'(s_axis_tdata);

	// ==========================================================================
	// frame state machine
	// ==========================================================================

	always_ff @(posedge aclk)
	begin
		if (!rst_n)
		begin
			state <= S_CMD;
			word_idx <= '0;
			key_q <= '0;
			ctr_q <= '0;
			blk_valid <= 1'b0;
		end
		else
		begin
			blk_valid <= 1'b0;
			// counter steps once the request has gone out
			if (blk_valid)
				ctr_q <= ctr_q + 1'b1;
			if (accept)
			begin
				word_idx <= word_idx + 1'b1;
				case (state)
					S_CMD:
					begin
						word_idx <= '0;
						if (cmd.opcode == OP_CRYPT)
							ctr_q <= '0;
						if (s_axis_tlast)
							state <= S_CMD;
						else if (cmd.opcode == OP_KEY)
							state <= S_KEY;
						else if (cmd.opcode == OP_CRYPT)
							state <= S_DATA;
						else
							state <= S_SKIP;
					end
					S_KEY:
					begin
						key_q[word_idx*32 +: 32] <= s_axis_tdata;
						if (s_axis_tlast)
							state <= S_CMD;
					end
					S_DATA:
					begin
						if (word_idx == 2'd3)
							blk_valid <= 1'b1;
						if (s_axis_tlast)
							state <= S_CMD;
					end
					default:
					begin
						if (s_axis_tlast)
							state <= S_CMD;
					end
				endcase
			end
		end
	end

	// payload and nonce capture
	always_ff @(posedge aclk)
	begin
		if (accept && state == S_CMD && cmd.opcode == OP_CRYPT)
			nonce_q <= cmd.nonce;
		if (accept && state == S_DATA)
		begin
			shift_q <= {s_axis_tdata, shift_q[127:32]};
			last_q <= s_axis_tlast;
		end
	end

	assign blk_data = shift_q;

	always_comb
	begin
		ks_req.key = key_q;
		ks_req.nonce = nonce_q;
		ks_req.counter = ctr_q;
		ks_req.last = last_q;
	end

endmodule

`default_nettype wire

// File: axis_block_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

module axis_block_unpacker
	import ctr_pkg::*;
(
	input  logic       aclk,
	input  logic       rst_n,
	input  logic       res_valid,
	input  res_block_t res,
	output logic       res_pop,
	output logic       m_axis_tvalid,
	output logic       m_axis_tlast,
	output word_t      m_axis_tdata,
	input  logic       m_axis_tready
);

	res_block_t hold_q;
	logic busy_q;
	logic [1:0] idx_q;
	logic beat;
	logic last_beat;

	assign beat = m_axis_tvalid && m_axis_tready;
	assign last_beat = beat && (idx_q == 2'd3);

	// next block loads when idle or as word 3 leaves
	assign res_pop = res_valid && (!busy_q || last_beat);

	// ==========================================================================
	// word output
	// ==========================================================================

	assign m_axis_tvalid = busy_q;
	assign m_axis_tdata = hold_q.data[idx_q*32 +: 32];
	assign m_axis_tlast = busy_q && hold_q.last && (idx_q == 2'd3);

	always_ff @(posedge aclk)
	begin
		if (!rst_n)
		begin
			busy_q <= 1'b0;
			idx_q <= '0;
		end
		else if (res_pop)
		begin
			busy_q <= 1'b1;
			idx_q <= '0;
		end
		else if (last_beat)
		begin
			busy_q <= 1'b0;
			idx_q <= '0;
		end
		else if (beat)
			idx_q <= idx_q + 1'b1;
	end

	// block register, no reset
	always_ff @(posedge aclk)
	begin
		if (res_pop)
			hold_q <= res;
	end

endmodule

`default_nettype wire

// File: block_combiner.sv
`timescale 1ns/100ps
`default_nettype none

module block_combiner
	import ctr_pkg::*;
#(
	parameter int ROUNDS = 4,
	parameter int OUT_DEPTH = 8
) (
	input  logic       aclk,
	input  logic       rst_n,
	input  logic       blk_valid,
	input  block_t     blk_data,
	input  logic       ks_valid,
	input  block_t     ks_block,
	input  logic       ks_last,
	output logic       space_ok,
	output logic       res_valid,
	output res_block_t res,
	input  logic       res_pop
);

	localparam int PEND_DEPTH = ROUNDS + 1;
	localparam int PEND_CW = $clog2(PEND_DEPTH + 1);
	localparam int RES_CW = $clog2(OUT_DEPTH + 1);

	block_t pend_data;
	logic pend_empty;
	logic pend_pop;
	logic [PEND_CW-1:0] pend_count;
	logic [PEND_CW:0] in_flight;
	res_block_t res_in;
	logic res_empty;
	logic [RES_CW-1:0] res_count;

	// payload waiting for its keystream
	sync_fifo #(.entry_t(block_t), .DEPTH(PEND_DEPTH)) pend_fifo (
		.aclk(aclk),
		.rst_n(rst_n),
		.push(blk_valid),
		.pop(pend_pop),
		.wdata(blk_data),
		.rdata(pend_data),
		.empty(pend_empty),
		.count(pend_count)
	);

	assign pend_pop = ks_valid && !pend_empty;
	assign res_in = '{data: pend_data ^ ks_block, last: ks_last};

	sync_fifo #(.entry_t(res_block_t), .DEPTH(OUT_DEPTH)) res_fifo (
		.aclk(aclk),
		.rst_n(rst_n),
		.push(pend_pop),
		.pop(res_pop),
		.wdata(res_in),
		.rdata(res),
		.empty(res_empty),
		.count(res_count)
	);

	assign res_valid = !res_empty;

	// blocks issued but not yet in the result fifo
	assign in_flight = pend_count + blk_valid;
	assign space_ok = (int'(res_count) + int'(in_flight) + ROUNDS + 1) < OUT_DEPTH;

endmodule

`default_nettype wire

// File: ctr_keystream.sv
`timescale 1ns/100ps
`default_nettype none

module ctr_keystream
	import ctr_pkg::*;
#(
	parameter int ROUNDS = 4
) (
	input  logic    aclk,
	input  logic    rst_n,
	input  logic    req_valid,
	input  ks_req_t req,
	output logic    ks_valid,
	output block_t  ks_block,
	output logic    ks_last
);

	typedef struct packed {
		block_t state;
		block_t key;
		logic   last;
	} stage_t;

	// one add-rotate-xor round, lanes then shift down by one
	function automatic block_t ks_round(block_t s);
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		a = s[31:0];
		b = s[63:32];
		c = s[95:64];
		d = s[127:96];
		a = a + b;
		d = d ^ a;
		d = {d[15:0], d[31:16]};
		c = c + d;
		b = b ^ c;
		b = {b[19:0], b[31:20]};
		// new lane 0 is old lane 1, new lane 3 is old lane 0
		return {a, d, c, b};
	endfunction

	block_t init_state;
	stage_t stg_q [ROUNDS];
	logic vld_q [ROUNDS];

	assign init_state = {req.key[127:96] ^ KS_CONST,
	                     req.key[95:64],
	                     req.key[63:32] ^ req.counter,
	                     req.key[31:0] ^ {8'h00, req.nonce}};

	// ==========================================================================
	// round pipeline
	// ==========================================================================

	for (genvar i = 0; i < ROUNDS; i++)
	begin : g_stage
		stage_t s_in;
		logic v_in;

		if (i == 0)
		begin : g_head
			assign s_in = '{state: init_state, key: req.key, last: req.last};
			assign v_in = req_valid;
		end
		else
		begin : g_tail
			assign s_in = stg_q[i-1];
			assign v_in = vld_q[i-1];
		end

		always_ff @(posedge aclk)
		begin
			if (!rst_n)
				vld_q[i] <= 1'b0;
			else
				vld_q[i] <= v_in;
		end

		always_ff @(posedge aclk)
		begin
			stg_q[i] <= '{state: ks_round(s_in.state), key: s_in.key, last: s_in.last};
		end
	end

	assign ks_valid = vld_q[ROUNDS-1];
	assign ks_last = stg_q[ROUNDS-1].last;

	// final key addition, per word
	always_comb
	begin
		for (int j = 0; j < 4; j++)
			ks_block[j*32 +: 32] = stg_q[ROUNDS-1].state[j*32 +: 32] + stg_q[ROUNDS-1].key[j*32 +: 32];
	end

endmodule

`default_nettype wire

// File: ctr_pkg.sv
`default_nettype none

package ctr_pkg;

	// ==========================================================================
	// stream and block types
	// ==========================================================================

	typedef logic [31:0] word_t;

	// word 0 sits in bits 31:0
	typedef logic [127:0] block_t;

	typedef enum logic [1:0]
	{
		OP_KEY   = 2'b01,
		OP_CRYPT = 2'b10
	} opcode_t;

	// first word of every input frame
	typedef struct packed {
		opcode_t     opcode;
		logic [5:0]  rsvd;
		logic [23:0] nonce;
	} cmd_t;

	// one keystream job, issued per payload block
	typedef struct packed {
		block_t      key;
		logic [23:0] nonce;
		word_t       counter;
		logic        last;
	} ks_req_t;

	typedef struct packed {
		block_t data;
		logic   last;
	} res_block_t;

	// fills lane 3 of the initial state
	localparam word_t KS_CONST = 32'h6170_7865;

endpackage

`default_nettype wire

// File: ctr_stream_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module ctr_stream_assertions
	import ctr_pkg::*;
(
	input logic  aclk,
	input logic  rst_n,
	input logic  s_axis_tvalid,
	input logic  s_axis_tready,
	input word_t s_axis_tdata,
	input logic  s_axis_tlast,
	input logic  m_axis_tvalid,
	input logic  m_axis_tready,
	input word_t m_axis_tdata,
	input logic  m_axis_tlast
);

	// read by the testbench at the end of the run
	int fail_count = 0;

	// ==========================================================================
	// slave stream
	// ==========================================================================

	a_s_valid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid)
		else
		begin
			fail_count = fail_count + 1;
			$error("s_axis_tvalid dropped before ready");
		end

	a_s_stable: assert property (@(posedge aclk) disable iff (!rst_n)
		s_axis_tvalid && !s_axis_tready |=> $stable(s_axis_tdata) && $stable(s_axis_tlast))
		else
		begin
			fail_count = fail_count + 1;
			$error("s_axis data or last changed while stalled");
		end

	// ==========================================================================
	// master stream
	// ==========================================================================

	a_m_valid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid)
		else
		begin
			fail_count = fail_count + 1;
			$error("m_axis_tvalid dropped before ready");
		end

	a_m_stable: assert property (@(posedge aclk) disable iff (!rst_n)
		m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata) && $stable(m_axis_tlast))
		else
		begin
			fail_count = fail_count + 1;
			$error("m_axis data or last changed while stalled");
		end

	a_m_last_valid: assert property (@(posedge aclk) disable iff (!rst_n)
		m_axis_tlast |-> m_axis_tvalid)
		else
		begin
			fail_count = fail_count + 1;
			$error("m_axis_tlast high without m_axis_tvalid");
		end

endmodule

bind ctr_stream_top ctr_stream_assertions protocol_checks (
	.aclk(aclk),
	.rst_n(rst_n),
	.s_axis_tvalid(s_axis_tvalid),
	.s_axis_tready(s_axis_tready),
	.s_axis_tdata(s_axis_tdata),
	.s_axis_tlast(s_axis_tlast),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tready(m_axis_tready),
	.m_axis_tdata(m_axis_tdata),
	.m_axis_tlast(m_axis_tlast)
);

`default_nettype wire

// File: ctr_stream_top.sv
`timescale 1ns/100ps
`default_nettype none

module ctr_stream_top
	import ctr_pkg::*;
#(
	parameter int ROUNDS = 4,
	// at least ROUNDS + 2
	parameter int OUT_DEPTH = 8
) (
	input  logic  aclk,
	input  logic  rst_n,
	input  logic  s_axis_tvalid,
	output logic  s_axis_tready,
	input  word_t s_axis_tdata,
	input  logic  s_axis_tlast,
	output logic  m_axis_tvalid,
	input  logic  m_axis_tready,
	output word_t m_axis_tdata,
	output logic  m_axis_tlast
);

	logic space_ok;
	logic blk_valid;
	block_t blk_data;
	ks_req_t ks_req;
	logic ks_valid;
	block_t ks_block;
	logic ks_last;
	logic res_valid;
	res_block_t res;
	logic res_pop;

	// ==========================================================================
	// slave side
	// ==========================================================================

	axis_block_packer packer (
		.aclk(aclk),
		.rst_n(rst_n),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tready(s_axis_tready),
		.space_ok(space_ok),
		.blk_valid(blk_valid),
		.blk_data(blk_data),
		.ks_req(ks_req)
	);

	// ==========================================================================
	// keystream and combine
	// ==========================================================================

	ctr_keystream #(.ROUNDS(ROUNDS)) keystream (
		.aclk(aclk),
		.rst_n(rst_n),
		.req_valid(blk_valid),
		.req(ks_req),
		.ks_valid(ks_valid),
		.ks_block(ks_block),
		.ks_last(ks_last)
	);

	block_combiner #(.ROUNDS(ROUNDS), .OUT_DEPTH(OUT_DEPTH)) combiner (
		.aclk(aclk),
		.rst_n(rst_n),
		.blk_valid(blk_valid),
		.blk_data(blk_data),
		.ks_valid(ks_valid),
		.ks_block(ks_block),
		.ks_last(ks_last),
		.space_ok(space_ok),
		.res_valid(res_valid),
		.res(res),
		.res_pop(res_pop)
	);

	// ==========================================================================
	// master side
	// ==========================================================================

	axis_block_unpacker unpacker (
		.aclk(aclk),
		.rst_n(rst_n),
		.res_valid(res_valid),
		.res(res),
		.res_pop(res_pop),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tready(m_axis_tready)
	);

endmodule

`default_nettype wire

// File: sources.f
ctr_pkg.sv
sync_fifo.sv
axis_block_packer.sv
ctr_keystream.sv
block_combiner.sv
axis_block_unpacker.sv
ctr_stream_top.sv
ctr_stream_assertions.sv
tb_ctr_stream.sv

// File: sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic                         aclk,
	input  logic                         rst_n,
	input  logic                         push,
	input  logic                         pop,
	input  entry_t                       wdata,
	output entry_t                       rdata,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign do_pop = pop && !empty;
	// a full fifo still takes a word when one leaves in the same cycle
	assign do_push = push && (!full || do_pop);

	// first-word fall-through
	assign rdata = mem[rd_ptr];

	always_ff @(posedge aclk)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge aclk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: tb_ctr_stream.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ctr_stream
	import ctr_pkg::*;
();

	localparam int ROUNDS = 4;
	localparam int OUT_DEPTH = 8;
	// input words per test: key, single, multi, stall, loopback, rekey
	localparam int TOTAL_WORDS = 5 + 5 + 30 + 51 + 18 + 10;
	localparam int CYCLE_LIMIT = TOTAL_WORDS * 4 + 500;

	logic aclk = 1'b0;
	logic rst_n;
	logic s_axis_tvalid;
	logic s_axis_tready;
	word_t s_axis_tdata;
	logic s_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready;
	word_t m_axis_tdata;
	logic m_axis_tlast;

	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	int assert_fails;
	logic gap_en = 1'b0;
	logic stall_en = 1'b0;
	block_t model_key = '0;
	word_t pt_q[$];
	word_t orig_q[$];
	word_t rx_q[$];
	word_t exp_data_q[$];
	logic exp_last_q[$];

	ctr_stream_top #(.ROUNDS(ROUNDS), .OUT_DEPTH(OUT_DEPTH)) DUT (
		.aclk(aclk),
		.rst_n(rst_n),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tlast(s_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tlast(m_axis_tlast)
	);

	always #50 aclk = ~aclk;

	// output back-pressure
	always @(posedge aclk)
	begin
		#1;
		if (stall_en)
			m_axis_tready = (($urandom % 2) == 0);
		else
			m_axis_tready = 1'b1;
	end

	// ==========================================================================
	// reference model
	// ==========================================================================

	function automatic word_t rotl(input word_t x, input int n);
		return (x << n) | (x >> (32 - n));
	endfunction

	function automatic block_t model_ks(input block_t key, input logic [23:0] nonce,
		input word_t ctr);
		word_t l [4];
		word_t k [4];
		word_t t;
		block_t ks;
		for (int i = 0; i < 4; i++)
			k[i] = key[i*32 +: 32];
		l[0] = k[0] ^ {8'h00, nonce};
		l[1] = k[1] ^ ctr;
		l[2] = k[2];
		l[3] = k[3] ^ KS_CONST;
		for (int r = 0; r < ROUNDS; r++)
		begin
			l[0] = l[0] + l[1];
			l[3] = rotl(l[3] ^ l[0], 16);
			l[2] = l[2] + l[3];
			l[1] = rotl(l[1] ^ l[2], 12);
			// lanes move down one place
			t = l[0];
			l[0] = l[1];
			l[1] = l[2];
			l[2] = l[3];
			l[3] = t;
		end
		for (int i = 0; i < 4; i++)
			ks[i*32 +: 32] = l[i] + k[i];
		return ks;
	endfunction

	// ==========================================================================
	// checking and output monitor
	// ==========================================================================

	task automatic check(input word_t got, input word_t expected, input string what);
		if (got !== expected)
		begin
			value_errors++;
			$display("ERROR: %0t ns: %s: got %h, expected %h", $time, what, got, expected);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge aclk)
	begin
		if (rst_n === 1'b1 && m_axis_tvalid && m_axis_tready)
		begin
			rx_q.push_back(m_axis_tdata);
			if (exp_data_q.size() == 0)
			begin
				other_errors++;
				$display("unexpected output word %h at %0t ns", m_axis_tdata, $time);
			end
			else
			begin
				check(m_axis_tdata, exp_data_q.pop_front(), "m_axis_tdata");
				check(word_t'(m_axis_tlast), word_t'(exp_last_q.pop_front()), "m_axis_tlast");
			end
		end
	end

	// ==========================================================================
	// stimulus helpers
	// ==========================================================================

	// called and returns 1 ns after a rising edge
	task automatic send_word(input word_t data, input logic last);
		int gap;
		logic done;
		gap = gap_en ? ($urandom % 3) : 0;
		s_axis_tvalid = 1'b0;
		repeat (gap)
		begin
			@(posedge aclk);
			#1;
		end
		s_axis_tvalid = 1'b1;
		s_axis_tdata = data;
		s_axis_tlast = last;
		done = 1'b0;
		while (!done)
		begin
			@(negedge aclk);
			done = s_axis_tready;
			@(posedge aclk);
			#1;
		end
	endtask

	task automatic end_frame();
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	task automatic send_key(input block_t key);
		cmd_t c;
		c.opcode = OP_KEY;
		c.rsvd = '0;
		c.nonce = '0;
		send_word(word_t'(c), 1'b0);
		for (int i = 0; i < 4; i++)
			send_word(key[i*32 +: 32], i == 3);
		end_frame();
		model_key = key;
	endtask

	task automatic send_crypt(input logic [23:0] nonce);
		cmd_t c;
		c.opcode = OP_CRYPT;
		c.rsvd = '0;
		c.nonce = nonce;
		send_word(word_t'(c), 1'b0);
		for (int i = 0; i < pt_q.size(); i++)
			send_word(pt_q[i], i == pt_q.size() - 1);
		end_frame();
	endtask

	// payload XOR keystream, counter restarting at zero
	task automatic expect_crypt(input logic [23:0] nonce);
		block_t ks;
		int nb;
		nb = pt_q.size() / 4;
		for (int b = 0; b < nb; b++)
		begin
			ks = model_ks(model_key, nonce, word_t'(b));
			for (int w = 0; w < 4; w++)
			begin
				exp_data_q.push_back(pt_q[b*4 + w] ^ ks[w*32 +: 32]);
				exp_last_q.push_back(b == nb - 1 && w == 3);
			end
		end
	endtask

	task automatic fill_random(input int blocks);
		pt_q.delete();
		for (int i = 0; i < blocks * 4; i++)
			pt_q.push_back($urandom);
	endtask

	task automatic wait_drain();
		while (exp_data_q.size() != 0)
			@(posedge aclk);
		#1;
	endtask

	// ==========================================================================
	// directed tests
	// ==========================================================================

	task automatic test_reset_and_key();
		check(word_t'(m_axis_tvalid), 32'd0, "m_axis_tvalid after reset");
		check(word_t'(s_axis_tready), 32'd1, "s_axis_tready after reset");
		send_key({32'h0f1e_2d3c, 32'h4b5a_6978, 32'h8796_a5b4, 32'hc3d2_e1f0});
		// quiet window longer than the pipeline latency
		repeat (ROUNDS + 10) @(posedge aclk);
		#1;
		check(rx_q.size(), 32'd0, "output words after key frame");
	endtask

	task automatic test_single_block();
		fill_random(1);
		expect_crypt(24'h00_1234);
		send_crypt(24'h00_1234);
		wait_drain();
	endtask

	task automatic test_counter_sequence();
		fill_random(5);
		expect_crypt(24'hab_cdef);
		send_crypt(24'hab_cdef);
		// new nonce, counter back at zero
		fill_random(2);
		expect_crypt(24'h13_5790);
		send_crypt(24'h13_5790);
		wait_drain();
	endtask

	task automatic test_random_stalls();
		logic [23:0] nonce;
		gap_en = 1'b1;
		stall_en = 1'b1;
		for (int f = 0; f < 3; f++)
		begin
			nonce = 24'($urandom);
			fill_random(4);
			expect_crypt(nonce);
			send_crypt(nonce);
		end
		wait_drain();
		gap_en = 1'b0;
		stall_en = 1'b0;
	endtask

	task automatic test_loopback();
		fill_random(2);
		orig_q = pt_q;
		rx_q.delete();
		expect_crypt(24'h5a_a55a);
		send_crypt(24'h5a_a55a);
		wait_drain();
		// decrypt the captured ciphertext
		pt_q = rx_q;
		for (int i = 0; i < orig_q.size(); i++)
		begin
			exp_data_q.push_back(orig_q[i]);
			exp_last_q.push_back(i == orig_q.size() - 1);
		end
		send_crypt(24'h5a_a55a);
		wait_drain();
	endtask

	task automatic test_new_key();
		send_key({$urandom, $urandom, $urandom, $urandom});
		fill_random(1);
		expect_crypt(24'h00_1234);
		send_crypt(24'h00_1234);
		wait_drain();
	endtask

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial
	begin
		void'($urandom(32'h9fbe_99bb));
		rst_n = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata = '0;
		s_axis_tlast = 1'b0;
		m_axis_tready = 1'b1;
		repeat (4) @(posedge aclk);
		#1;
		rst_n = 1'b1;
		test_reset_and_key();
		test_single_block();
		test_counter_sequence();
		test_random_stalls();
		test_loopback();
		test_new_key();
		repeat (4) @(posedge aclk);
		assert_fails = DUT.protocol_checks.fail_count;
		$display("checks done: %0d value errors, %0d other errors, %0d assertion failures",
			value_errors, other_errors, assert_fails);
		if (value_errors == 0 && other_errors == 0 && assert_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// run limit
	initial
	begin
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge aclk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
